// ==== hwpe_pkg.sv ====
/*
 * hwpe control package
 * register map, widths, port structs and test-set response codes
 */
`default_nettype none

package hwpe_pkg;

  // job contexts and widths
  localparam int n_context = 2;
  localparam int ctx_w     = 1;
  localparam int reg_w     = 3;
  localparam int src_w     = 2;
  localparam int data_w    = 32;
  localparam int job_id_w  = 8;

  // context select bit sits above the register index
  localparam int addr_w = ctx_w + reg_w;

  // mandatory registers
  localparam logic [reg_w-1:0] reg_trigger = 3'd0;
  localparam logic [reg_w-1:0] reg_acquire = 3'd1;
  localparam logic [reg_w-1:0] reg_status  = 3'd2;
  localparam logic [reg_w-1:0] reg_run_id  = 3'd3;
  localparam logic [reg_w-1:0] reg_owner   = 3'd4;
  // index 5 is reserved and reads 0
  // contexted I/O registers
  localparam logic [reg_w-1:0] reg_len     = 3'd6;
  localparam logic [reg_w-1:0] reg_param   = 3'd7;

  // test-set responses
  localparam logic [data_w-1:0] resp_offloading = {data_w{1'b1}} - 1'b1;
  localparam logic [data_w-1:0] resp_all_busy   = {data_w{1'b1}};

  typedef struct packed {
    logic [addr_w-1:0] addr;
    logic [data_w-1:0] wdata;
    logic              wen;
    logic [src_w-1:0]  src;
  } cfg_req_t;

  typedef struct packed {
    logic [data_w-1:0] rdata;
  } cfg_rsp_t;

  // decoded access of the accepted request
  typedef struct packed {
    logic is_read;
    logic is_testset;
    logic is_trigger;
    logic is_contexted;
    logic is_mandatory;
    logic is_critical;
    logic full_context;
  } access_flags_t;

  // job handed to the engine and returned as the done event
  typedef struct packed {
    logic [ctx_w-1:0]    ctx;
    logic [job_id_w-1:0] job_id;
    logic [data_w-1:0]   len;
    logic [data_w-1:0]   param;
  } job_t;

endpackage

`default_nettype wire

// ==== hwpe_cfg_slave.sv ====
/*
 * hwpe configuration slave
 * valid/ready port, access decode, offload lock and context pointer
 */
`default_nettype none

module hwpe_cfg_slave (
  input  logic                                 clk,
  input  logic                                 rst_n,
  input  logic                                 req_valid,
  input  hwpe_pkg::cfg_req_t                   req,
  output logic                                 req_ready,
  output logic                                 rsp_valid,
  output hwpe_pkg::cfg_rsp_t                   rsp,
  input  logic                                 rsp_ready,
  output hwpe_pkg::cfg_req_t                   acc_req,
  output hwpe_pkg::access_flags_t              flags,
  output logic [hwpe_pkg::ctx_w-1:0]           pointer_context,
  input  logic [hwpe_pkg::data_w-1:0]          rdata,
  input  logic [hwpe_pkg::n_context-1:0]       busy
);

  logic                        fire;
  logic [hwpe_pkg::reg_w-1:0]  idx;
  logic                        lock_held;
  logic [hwpe_pkg::src_w-1:0]  lock_src;
  logic                        is_holder;
  logic                        rd_fire;
  logic                        testset;
  logic                        critical;
  logic                        full;
  logic                        acquire_ok;
  logic [hwpe_pkg::ctx_w-1:0]  free_ctx;

  // a held response blocks new requests
  assign req_ready = !rsp_valid || rsp_ready;
  assign fire      = req_valid && req_ready;
  assign idx       = req.addr[hwpe_pkg::reg_w-1:0];
  assign acc_req   = req;

  assign is_holder  = lock_held && (req.src == lock_src);
  assign rd_fire    = fire && !req.wen;
  assign testset    = rd_fire && (idx == hwpe_pkg::reg_acquire);
  assign critical   = testset && lock_held && !is_holder;
  assign full       = &busy;
  assign acquire_ok = testset && !critical && !full;

  always_comb begin
    flags              = '0;
    flags.is_read      = rd_fire;
    flags.is_testset   = testset;
    // only the lock holder may fire its context
    flags.is_trigger   = fire && req.wen && (idx == hwpe_pkg::reg_trigger) && is_holder;
    flags.is_mandatory = fire && (idx <= hwpe_pkg::reg_owner);
    flags.is_contexted = fire && (idx >= hwpe_pkg::reg_len);
    flags.is_critical  = critical;
    flags.full_context = full;
  end

  // lowest free context
  always_comb begin
    free_ctx = '0;
    for (int i = hwpe_pkg::n_context - 1; i >= 0; i--) begin
      if (!busy[i]) begin
        free_ctx = i[hwpe_pkg::ctx_w-1:0];
      end
    end
  end

  // offload lock taken by test-set and released by the holder's trigger
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      lock_held       <= 1'b0;
      lock_src        <= '0;
      pointer_context <= '0;
    end else if (acquire_ok) begin
      lock_held       <= 1'b1;
      lock_src        <= req.src;
      pointer_context <= free_ctx;
    end else if (flags.is_trigger) begin
      lock_held <= 1'b0;
    end
  end

  // response handshake
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rsp_valid <= 1'b0;
    end else if (fire) begin
      rsp_valid <= 1'b1;
    end else if (rsp_ready) begin
      rsp_valid <= 1'b0;
    end
  end

  // data only loads on acceptance, so it holds under back-pressure
  always_ff @(posedge clk) begin
    if (fire) begin
      rsp.rdata <= rdata;
    end
  end

endmodule

`default_nettype wire

// ==== hwpe_regfile.sv ====
/*
 * hwpe register file
 * mandatory and contexted registers, job-id counters, read data mux
 */
`default_nettype none

module hwpe_regfile (
  input  logic                                 clk,
  input  logic                                 rst_n,
  input  hwpe_pkg::cfg_req_t                   acc_req,
  input  hwpe_pkg::access_flags_t              flags,
  input  logic [hwpe_pkg::ctx_w-1:0]           pointer_context,
  input  logic [hwpe_pkg::ctx_w-1:0]           running_context,
  input  logic                                 done,
  output logic [hwpe_pkg::data_w-1:0]          rdata,
  output logic [hwpe_pkg::n_context-1:0]       busy,
  output logic                                 trig_valid,
  output hwpe_pkg::job_t                       trig_job
);

  logic [hwpe_pkg::ctx_w-1:0]     acc_ctx;
  logic [hwpe_pkg::reg_w-1:0]     acc_idx;
  logic [hwpe_pkg::data_w-1:0]    ctx_len   [hwpe_pkg::n_context];
  logic [hwpe_pkg::data_w-1:0]    ctx_param [hwpe_pkg::n_context];
  logic [hwpe_pkg::n_context-1:0][7:0] owner;
  logic [7:0]                     owner_code;
  logic [hwpe_pkg::job_id_w-1:0]  offload_job_id;
  logic [hwpe_pkg::job_id_w-1:0]  running_job_id;
  logic [hwpe_pkg::job_id_w-1:0]  acq_job_id;
  logic                           acquire_ok;
  logic                           done_q;
  logic [hwpe_pkg::ctx_w-1:0]     done_ctx;
  logic [hwpe_pkg::data_w-1:0]    status_word;
  logic [hwpe_pkg::data_w-1:0]    owner_word;
  logic [hwpe_pkg::data_w-1:0]    io_rdata;
  logic [hwpe_pkg::data_w-1:0]    mand_rdata;

  assign acc_ctx    = acc_req.addr[hwpe_pkg::addr_w-1 -: hwpe_pkg::ctx_w];
  assign acc_idx    = acc_req.addr[hwpe_pkg::reg_w-1:0];
  assign owner_code = {{(8 - hwpe_pkg::src_w){1'b0}}, acc_req.src} + 8'd1;
  assign acquire_ok = flags.is_testset && !flags.is_critical && !flags.full_context;

  // contexted I/O registers
  always_ff @(posedge clk) begin
    if (flags.is_contexted && acc_req.wen) begin
      if (acc_idx == hwpe_pkg::reg_len) begin
        ctx_len[acc_ctx] <= acc_req.wdata;
      end else begin
        ctx_param[acc_ctx] <= acc_req.wdata;
      end
    end
  end

  // running job id follows done by one cycle
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      offload_job_id <= '0;
      acq_job_id     <= '0;
      running_job_id <= '0;
      done_q         <= 1'b0;
      done_ctx       <= '0;
    end else begin
      done_q   <= done;
      done_ctx <= running_context;
      if (acquire_ok) begin
        offload_job_id <= offload_job_id + 1'b1;
        acq_job_id     <= offload_job_id;
      end
      if (done_q) begin
        running_job_id <= running_job_id + 1'b1;
      end
    end
  end

  // busy and owner bytes
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy  <= '0;
      owner <= '0;
    end else begin
      for (int i = 0; i < hwpe_pkg::n_context; i++) begin
        if (flags.is_trigger && (pointer_context == i)) begin
          busy[i]  <= 1'b1;
          owner[i] <= owner_code;
        end else if (done_q && (done_ctx == i)) begin
          busy[i] <= 1'b0;
        end
      end
    end
  end

  // trigger pulse towards the job engine
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      trig_valid <= 1'b0;
    end else begin
      trig_valid <= flags.is_trigger;
    end
  end

  always_ff @(posedge clk) begin
    if (flags.is_trigger) begin
      trig_job.ctx    <= pointer_context;
      trig_job.job_id <= acq_job_id;
      trig_job.len    <= ctx_len[pointer_context];
      trig_job.param  <= ctx_param[pointer_context];
    end
  end

  // one byte per context
  always_comb begin
    status_word = '0;
    owner_word  = '0;
    for (int i = 0; i < hwpe_pkg::n_context; i++) begin
      status_word[8*i]     = busy[i];
      owner_word[8*i +: 8] = owner[i];
    end
  end

  assign io_rdata = (acc_idx == hwpe_pkg::reg_len) ? ctx_len[acc_ctx] : ctx_param[acc_ctx];

  always_comb begin
    case (acc_idx)
      hwpe_pkg::reg_status: mand_rdata = status_word;
      hwpe_pkg::reg_run_id: mand_rdata = {{(hwpe_pkg::data_w - hwpe_pkg::job_id_w){1'b0}},
                                          running_job_id};
      hwpe_pkg::reg_owner:  mand_rdata = owner_word;
      // trigger and reserved read 0
      default:              mand_rdata = '0;
    endcase
  end

  // test-set answer takes priority over plain reads
  always_comb begin
    if (flags.is_testset) begin
      if (flags.is_critical) begin
        rdata = hwpe_pkg::resp_offloading;
      end else if (flags.full_context) begin
        rdata = hwpe_pkg::resp_all_busy;
      end else begin
        rdata = {{(hwpe_pkg::data_w - hwpe_pkg::job_id_w){1'b0}}, offload_job_id};
      end
    end else if (flags.is_read && flags.is_contexted) begin
      rdata = io_rdata;
    end else if (flags.is_read && flags.is_mandatory) begin
      rdata = mand_rdata;
    end else begin
      rdata = '0;
    end
  end

endmodule

`default_nettype wire

// ==== hwpe_job_ctrl.sv ====
/*
 * hwpe job engine
 * trigger-order queue, length countdown and done event
 */
`default_nettype none

module hwpe_job_ctrl (
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic                         trig_valid,
  input  hwpe_pkg::job_t               trig_job,
  output logic                         done,
  output logic [hwpe_pkg::ctx_w-1:0]   running_context,
  output logic                         done_valid,
  output hwpe_pkg::job_t               done_job
);

  hwpe_pkg::job_t              q_mem [hwpe_pkg::n_context];
  logic [hwpe_pkg::ctx_w-1:0]  wr_ptr;
  logic [hwpe_pkg::ctx_w-1:0]  rd_ptr;
  logic [hwpe_pkg::ctx_w:0]    q_cnt;
  logic                        running;
  logic [hwpe_pkg::data_w-1:0] cnt;
  logic                        start;
  hwpe_pkg::job_t              cur_job;

  assign start    = !running && (q_cnt != '0);
  assign done     = done_valid;
  assign done_job = cur_job;

  // one slot per context so the queue never overflows
  always_ff @(posedge clk) begin
    if (trig_valid) begin
      q_mem[wr_ptr] <= trig_job;
    end
    if (start) begin
      cur_job <= q_mem[rd_ptr];
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr          <= '0;
      rd_ptr          <= '0;
      q_cnt           <= '0;
      running         <= 1'b0;
      cnt             <= '0;
      done_valid      <= 1'b0;
      running_context <= '0;
    end else begin
      done_valid <= 1'b0;
      if (trig_valid) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (start) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      q_cnt <= q_cnt + trig_valid - start;
      if (start) begin
        running         <= 1'b1;
        running_context <= q_mem[rd_ptr].ctx;
        // zero length still takes one cycle
        cnt <= (q_mem[rd_ptr].len == '0) ? 1 : q_mem[rd_ptr].len;
      end else if (running) begin
        if (cnt == 1) begin
          running    <= 1'b0;
          done_valid <= 1'b1;
        end else begin
          cnt <= cnt - 1'b1;
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== hwpe_ctrl_top.sv ====
/*
 * hwpe control top level
 * config slave, register file and job engine
 */
`default_nettype none

module hwpe_ctrl_top (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               req_valid,
  output logic               req_ready,
  input  hwpe_pkg::cfg_req_t req,
  output logic               rsp_valid,
  input  logic               rsp_ready,
  output hwpe_pkg::cfg_rsp_t rsp,
  output logic               done_valid,
  output hwpe_pkg::job_t     done_job
);

  hwpe_pkg::cfg_req_t                acc_req;
  hwpe_pkg::access_flags_t           flags;
  logic [hwpe_pkg::ctx_w-1:0]        pointer_context;
  logic [hwpe_pkg::ctx_w-1:0]        running_context;
  logic [hwpe_pkg::data_w-1:0]       rdata;
  logic [hwpe_pkg::n_context-1:0]    busy;
  logic                              trig_valid;
  hwpe_pkg::job_t                    trig_job;
  logic                              done;

  hwpe_cfg_slave u_slave (
    .clk             (clk),
    .rst_n           (rst_n),
    .req_valid       (req_valid),
    .req             (req),
    .req_ready       (req_ready),
    .rsp_valid       (rsp_valid),
    .rsp             (rsp),
    .rsp_ready       (rsp_ready),
    .acc_req         (acc_req),
    .flags           (flags),
    .pointer_context (pointer_context),
    .rdata           (rdata),
    .busy            (busy)
  );

  hwpe_regfile u_regfile (
    .clk             (clk),
    .rst_n           (rst_n),
    .acc_req         (acc_req),
    .flags           (flags),
    .pointer_context (pointer_context),
    .running_context (running_context),
    .done            (done),
    .rdata           (rdata),
    .busy            (busy),
    .trig_valid      (trig_valid),
    .trig_job        (trig_job)
  );

  hwpe_job_ctrl u_job_ctrl (
    .clk             (clk),
    .rst_n           (rst_n),
    .trig_valid      (trig_valid),
    .trig_job        (trig_job),
    .done            (done),
    .running_context (running_context),
    .done_valid      (done_valid),
    .done_job        (done_job)
  );

endmodule

`default_nettype wire

// ==== hwpe_ctrl_checker.sv ====
/*
 * hwpe control checker
 * handshake and done-event assertions, bound to the top level
 */
`default_nettype none

module hwpe_ctrl_checker (
  input logic               clk,
  input logic               rst_n,
  input logic               req_ready,
  input logic               rsp_valid,
  input logic               rsp_ready,
  input hwpe_pkg::cfg_rsp_t rsp,
  input logic               done_valid
);

  // a stalled response keeps its data
  rsp_hold: assert property (@(posedge clk) disable iff (!rst_n)
    rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp))
    else $error("response changed or dropped while stalled");

  // no new request while a response waits
  req_block: assert property (@(posedge clk) disable iff (!rst_n)
    rsp_valid && !rsp_ready |-> !req_ready)
    else $error("request port ready while a response is stalled");

  done_pulse: assert property (@(posedge clk) disable iff (!rst_n)
    done_valid |=> !done_valid)
    else $error("done event longer than one cycle");

endmodule

`default_nettype wire

// ==== tb_hwpe_ctrl.sv ====
/*
 * testbench for the hwpe control block
 * golden-file transactions, random response stall and done monitor
 */
`default_nettype none

module tb_hwpe_ctrl;

  localparam int max_lines  = 128;
  localparam int wait_limit = 1000;

  logic               clk;
  logic               rst_n;
  logic               req_valid;
  logic               req_ready;
  hwpe_pkg::cfg_req_t req;
  logic               rsp_valid;
  logic               rsp_ready;
  hwpe_pkg::cfg_rsp_t rsp;
  logic               done_valid;
  hwpe_pkg::job_t     done_job;

  // op, test, src, addr, wdata, expected
  logic [79:0] golden [max_lines];
  logic [31:0] exp_q [$];
  string       name_q [$];
  logic [31:0] done_id_q [$];
  logic [31:0] done_param_q [$];
  int          n_req = 0;
  int          n_rsp = 0;
  int          n_done = 0;

  hwpe_ctrl_top i_dut (
    .clk        (clk),
    .rst_n      (rst_n),
    .req_valid  (req_valid),
    .req_ready  (req_ready),
    .req        (req),
    .rsp_valid  (rsp_valid),
    .rsp_ready  (rsp_ready),
    .rsp        (rsp),
    .done_valid (done_valid),
    .done_job   (done_job)
  );

  bind hwpe_ctrl_top hwpe_ctrl_checker i_checker (
    .clk        (clk),
    .rst_n      (rst_n),
    .req_ready  (req_ready),
    .rsp_valid  (rsp_valid),
    .rsp_ready  (rsp_ready),
    .rsp        (rsp),
    .done_valid (done_valid)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Some tests failed");
    $fatal(1, "run aborted");
  endtask

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected) begin
      abort_run($sformatf("ERR %s: expected %h, actual %h", name, expected, actual));
    end
  endtask

  function automatic string test_label(input logic [3:0] test);
    case (test)
      4'd1:    return "acquire";
      4'd2:    return "io registers";
      4'd3:    return "status and owner";
      4'd4:    return "job order";
      default: return "backpressure";
    endcase
  endfunction

  // called on a falling edge, returns on a falling edge
  task automatic send_request(input logic [79:0] entry, input int line);
    int waited;
    waited    = 0;
    req.src   = entry[69:68];
    req.addr  = entry[67:64];
    req.wdata = entry[63:32];
    req.wen   = (entry[79:76] == 4'd2);
    req_valid = 1'b1;
    // sample ready once the stall input has settled
    #1;
    while (!req_ready && waited < wait_limit) begin
      @(negedge clk);
      #1;
      waited++;
    end
    if (!req_ready) begin
      abort_run($sformatf("request of entry %0d was never accepted", line));
    end else begin
      exp_q.push_back(entry[31:0]);
      name_q.push_back($sformatf("%s entry %0d", test_label(entry[75:72]), line));
      n_req++;
      @(negedge clk);
      req_valid = 1'b0;
    end
  endtask

  task automatic wait_done(input int count);
    int waited;
    waited = 0;
    do begin
      @(posedge clk);
      waited++;
    end while (n_done < count && waited < wait_limit);
    if (n_done < count) begin
      abort_run($sformatf("done event %0d did not arrive in time", count - 1));
    end else begin
      @(negedge clk);
    end
  endtask

  // response side with random stall
  initial begin
    void'($urandom(84056));
    rsp_ready = 1'b0;
    forever begin
      @(negedge clk);
      rsp_ready = ($urandom % 4) != 0;
      if (rsp_valid && rsp_ready) begin
        if (exp_q.size() == 0) begin
          abort_run("response arrived without a pending request");
        end else begin
          check_value(name_q.pop_front(), exp_q.pop_front(), rsp.rdata);
          n_rsp++;
        end
      end
    end
  end

  // done events in trigger order
  initial begin
    forever begin
      @(negedge clk);
      if (done_valid) begin
        if (done_id_q.size() == 0) begin
          abort_run("done event that the golden list does not expect");
        end else begin
          check_value($sformatf("job order done %0d id", n_done), done_id_q.pop_front(),
                      {{(32 - hwpe_pkg::job_id_w){1'b0}}, done_job.job_id});
          check_value($sformatf("job order done %0d param", n_done),
                      done_param_q.pop_front(), done_job.param);
          n_done++;
        end
      end
    end
  end

  initial begin
    int          idx;
    int          n_wait;
    int          waited;
    logic [79:0] entry;
    rst_n     = 1'b0;
    req_valid = 1'b0;
    req       = '0;
    for (int i = 0; i < max_lines; i++) begin
      golden[i] = '0;
    end
    $readmemh("hwpe_golden.txt", golden);
    for (int i = 0; i < max_lines; i++) begin
      if (golden[i][79:76] == 4'd3) begin
        done_id_q.push_back(golden[i][63:32]);
        done_param_q.push_back(golden[i][31:0]);
      end
    end
    repeat (10) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    idx    = 0;
    n_wait = 0;
    // op 0 ends the list
    while (idx < max_lines && golden[idx][79:76] != 4'd0) begin
      entry = golden[idx];
      case (entry[79:76])
        4'd1, 4'd2: send_request(entry, idx);
        4'd3: begin
          n_wait++;
          wait_done(n_wait);
        end
        4'd4: repeat (entry[63:32]) @(negedge clk);
        default: ;
      endcase
      idx++;
    end
    waited = 0;
    do begin
      @(posedge clk);
      waited++;
    end while (n_rsp != n_req && waited < wait_limit);
    if (n_rsp == n_req) begin
      $display("All tests passed");
      $finish;
    end else begin
      $display("responses %0d for %0d requests", n_rsp, n_req);
      $display("Some tests failed");
      $fatal(1, "response count mismatch");
    end
  end

endmodule

`default_nettype wire

// ==== hwpe_golden.txt ====
// columns: op _ test _ src _ addr _ wdata _ expected rdata
// op 1 read, 2 write, 3 done (wdata job id, expected param), 4 idle (wdata cycles)
// io registers of both contexts, trigger and reserved read 0
2_2_0_6_00000040_00000000
2_2_0_7_a5a50001_00000000
2_2_1_e_00000020_00000000
2_2_1_f_5a5a0002_00000000
1_2_2_6_00000000_00000040
1_2_2_7_00000000_a5a50001
1_2_3_e_00000000_00000020
1_2_3_f_00000000_5a5a0002
1_2_0_0_00000000_00000000
1_2_0_5_00000000_00000000
1_2_0_d_00000000_00000000
1_3_0_3_00000000_00000000
// core 0 offloads, core 1 runs into the lock
1_1_0_1_00000000_00000000
1_1_1_1_00000000_fffffffe
2_1_0_0_00000000_00000000
1_3_2_2_00000000_00000001
1_3_2_4_00000000_00000001
// core 1 takes context 1, core 3 finds both busy
1_1_1_1_00000000_00000001
2_1_1_0_00000000_00000000
1_1_3_1_00000000_ffffffff
1_3_3_2_00000000_00000101
1_3_3_4_00000000_00000201
3_4_0_0_00000000_a5a50001
4_3_0_0_00000004_00000000
1_3_0_2_00000000_00000100
1_3_0_3_00000000_00000001
3_4_0_0_00000001_5a5a0002
4_3_0_0_00000004_00000000
1_3_0_2_00000000_00000000
1_3_0_3_00000000_00000002
// back to back offload by cores 2 and 3
2_4_2_6_00000010_00000000
2_4_2_7_c0de0003_00000000
2_4_3_e_00000000_00000000
2_4_3_f_c0de0004_00000000
1_4_2_1_00000000_00000002
2_4_2_0_00000000_00000000
1_4_3_1_00000000_00000003
2_4_3_0_00000000_00000000
3_4_0_0_00000002_c0de0003
3_4_0_0_00000003_c0de0004
4_3_0_0_00000004_00000000
1_3_0_2_00000000_00000000
1_3_0_3_00000000_00000004
1_3_0_4_00000000_00000403
// read burst under response stall
1_5_1_7_00000000_c0de0003
1_5_2_f_00000000_c0de0004
1_5_0_6_00000000_00000010
1_5_3_1_00000000_00000004
1_5_0_1_00000000_fffffffe

// ==== sim.f ====
hwpe_pkg.sv
hwpe_cfg_slave.sv
hwpe_regfile.sv
hwpe_job_ctrl.sv
hwpe_ctrl_top.sv
hwpe_ctrl_checker.sv
tb_hwpe_ctrl.sv

// ==== Makefile ====
VERILATOR ?= verilator
FLAGS     ?= --binary --assert -Wno-fatal -j 0
TOP       ?= tb_hwpe_ctrl
FILELIST  ?= sim.f

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build and run the testbench with Verilator"
	@echo "  clean  remove the build directory"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir
